// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // Datapath and address width
    localparam int xlen = 64;

    // Instruction word width
    localparam int ilen = 32;

    // Major opcodes, instruction bits 6:0
    localparam logic [6:0] opc_lui    = 7'b0110111;    // LUI
    localparam logic [6:0] opc_op_imm = 7'b0010011;    // Integer register-immediate group
    localparam logic [6:0] opc_load   = 7'b0000011;    // Loads
    localparam logic [6:0] opc_store  = 7'b0100011;    // Stores

    // funct3 values we care about
    localparam logic [2:0] f3_addi  = 3'b000;
    localparam logic [2:0] f3_dword = 3'b011;          // 64-bit width for LD and SD

    // MRET is matched on the whole word
    localparam logic [ilen-1:0] mret_word = 32'h30200073;

    // Operations seen by execute, anything unknown becomes op_nop
    typedef enum logic [2:0] {
        op_nop  = 3'd0,
        op_lui  = 3'd1,
        op_addi = 3'd2,
        op_ld   = 3'd3,
        op_sd   = 3'd4,
        op_mret = 3'd5
    } op_t;

    // Decoded instruction in the ir stage
    typedef struct packed {
        logic            valid;     // Word is live, cleared by reset or flush
        op_t             op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;       // Already sign-extended for the format
        logic [xlen-1:0] pc;        // Fetch address of this word
    } decoded_t;

    // One-beat data bus request
    typedef struct packed {
        logic            read;      // Data returns on the following cycle
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } bus_req_t;

    // Register file write
    typedef struct packed {
        logic            en;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

    // Defaults for the top-level parameters
    localparam logic [xlen-1:0] default_reset_pc    = 64'h1000;  // First fetch
    localparam logic [xlen-1:0] default_trap_vector = 64'h0;     // Interrupt handler entry

endpackage

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [rv_core_pkg::ilen-1:0]        instruction,   // Word at fetch_pc
    input  logic [rv_core_pkg::xlen-1:0]        fetch_pc,
    input  logic                                flush,         // Kill the word being fetched
    output rv_core_pkg::decoded_t               ir
);
    import rv_core_pkg::*;

    logic            word_valid;
    logic [ilen-1:0] word;
    logic [xlen-1:0] word_pc;

    // Fields of the registered word
    logic [6:0]      opcode;
    logic [2:0]      funct3;

    // Immediates for each format
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;

    // Valid bit, the only control state here
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= !flush;           // Redirect or stall drops this fetch
        end
    end

    // Fetched word and its address
    always_ff @(posedge clk) begin
        word    <= instruction;
        word_pc <= fetch_pc;
    end

    assign opcode = word[6:0];
    assign funct3 = word[14:12];

    // U form, upper 20 bits then sign-extend from bit 31
    assign imm_u = {{32{word[31]}}, word[31:12], 12'b0};
    // I form
    assign imm_i = {{52{word[31]}}, word[31:20]};
    // S form, split immediate
    assign imm_s = {{52{word[31]}}, word[31:25], word[11:7]};

    always_comb begin
        ir.valid = word_valid;
        ir.rd    = word[11:7];
        ir.rs1   = word[19:15];
        ir.rs2   = word[24:20];
        ir.pc    = word_pc;
        ir.op    = op_nop;          // Unknown encodings retire as no-ops
        ir.imm   = imm_i;

        case (opcode)
            opc_lui: begin
                ir.op  = op_lui;
                ir.imm = imm_u;
            end
            opc_op_imm: begin
                if (funct3 == f3_addi) begin
                    ir.op = op_addi;
                end
            end
            opc_load: begin
                if (funct3 == f3_dword) begin
                    ir.op = op_ld;  // Byte/word loads are not supported
                end
            end
            opc_store: begin
                ir.imm = imm_s;
                if (funct3 == f3_dword) begin
                    ir.op = op_sd;
                end
            end
            default: begin
                // SYSTEM group, only the exact MRET word counts
                if (word == mret_word) begin
                    ir.op = op_mret;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_execute #(
    parameter logic [rv_core_pkg::xlen-1:0] reset_pc    = rv_core_pkg::default_reset_pc,
    parameter logic [rv_core_pkg::xlen-1:0] trap_vector = rv_core_pkg::default_trap_vector
) (
    input  logic                                clk,
    input  logic                                reset,
    input  rv_core_pkg::decoded_t               ir,
    input  logic [rv_core_pkg::xlen-1:0]        rs1_data,
    input  logic [rv_core_pkg::xlen-1:0]        rs2_data,
    input  logic                                interrupt_req,      // Level
    input  logic [rv_core_pkg::xlen-1:0]        bus_read_data,      // Valid cycle after read
    output logic [rv_core_pkg::xlen-1:0]        pc,
    output logic                                flush,
    output logic [4:0]                          rs1_addr,
    output logic [4:0]                          rs2_addr,
    output rv_core_pkg::bus_req_t               bus,
    output rv_core_pkg::wb_t                    wb,
    output logic                                interrupt_ack,      // One-cycle strobe
    output logic                                interrupt_pending
);
    import rv_core_pkg::*;

    logic            bubble;        // Cycle after a redirect or stall
    logic            ld_step;       // Load data arrives this cycle
    logic [4:0]      ld_rd;         // Destination held across the load
    logic [xlen-1:0] mepc;          // Return address for MRET

    logic            live;
    logic            take_irq;
    logic            do_lui;
    logic            do_addi;
    logic            do_ld;
    logic            do_sd;
    logic            do_mret;
    logic            stall;
    logic [xlen-1:0] sum;           // rs1 + imm, ADDI result and bus address
    logic [xlen-1:0] pc_next;

    // Register reads come straight from the decoded fields
    assign rs1_addr = ir.rs1;
    assign rs2_addr = ir.rs2;

    // An instruction counts only outside bubbles and open load steps
    assign live = ir.valid && !bubble && !ld_step;

    // Interrupt wins over the instruction in ir, which is replayed after MRET
    assign take_irq = live && interrupt_req && !interrupt_pending;

    assign do_lui  = live && !take_irq && (ir.op == op_lui);
    assign do_addi = live && !take_irq && (ir.op == op_addi);
    assign do_ld   = live && !take_irq && (ir.op == op_ld);
    assign do_sd   = live && !take_irq && (ir.op == op_sd);
    assign do_mret = live && !take_irq && (ir.op == op_mret);

    assign stall = do_ld || do_sd;              // Bus op holds pc for one cycle

    // Word being fetched now is on the wrong path or must be refetched
    assign flush = take_irq || stall || do_mret;

    assign sum = rs1_data + ir.imm;

    // Next pc selection
    always_comb begin
        if (take_irq) begin
            pc_next = trap_vector;
        end else if (do_mret) begin
            pc_next = mepc;
        end else if (stall) begin
            pc_next = pc;                       // Refetch the word after the bus op
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    // Bus strobes are combinational, one cycle each
    always_comb begin
        bus = '0;
        if (do_ld) begin
            bus.read = 1'b1;
            bus.addr = sum;
        end
        if (do_sd) begin
            bus.write = 1'b1;
            bus.addr  = sum;
            bus.wdata = rs2_data;               // Bypassed by the register file
        end
    end

    // Control state and registered writeback
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc                <= reset_pc;
            bubble            <= 1'b0;
            ld_step           <= 1'b0;
            interrupt_ack     <= 1'b0;
            interrupt_pending <= 1'b0;
            wb                <= '0;
        end else begin
            pc            <= pc_next;
            bubble        <= flush;
            ld_step       <= do_ld;             // Second cycle of LD
            interrupt_ack <= take_irq;

            if (take_irq) begin
                interrupt_pending <= 1'b1;
            end else if (do_mret) begin
                interrupt_pending <= 1'b0;
            end

            wb.en <= do_lui || do_addi || ld_step;
            if (ld_step) begin
                wb.rd   <= ld_rd;
                wb.data <= bus_read_data;       // Sampled a cycle after the strobe
            end else begin
                wb.rd   <= ir.rd;
                wb.data <= do_lui ? ir.imm : sum;
            end
        end
    end

    // Return address and load destination
    always_ff @(posedge clk) begin
        if (take_irq) begin
            mepc <= ir.pc;                      // Interrupted instruction reruns
        end
        if (do_ld) begin
            ld_rd <= ir.rd;
        end
    end

endmodule

`default_nettype wire

// ==== rv_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_result (
    input  logic                                clk,
    input  logic                                reset,
    input  rv_core_pkg::wb_t                    wb,
    input  logic [4:0]                          rs1_addr,
    input  logic [4:0]                          rs2_addr,
    output logic [rv_core_pkg::xlen-1:0]        rs1_data,
    output logic [rv_core_pkg::xlen-1:0]        rs2_data
);
    import rv_core_pkg::*;

    // x1..x31, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;     // Writes to x0 dropped
        end
    end

    // Read with bypass of the write landing this cycle
    function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
        logic [xlen-1:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wb.en && (wb.rd == addr)) begin
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
    end

    always_comb begin
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
    parameter logic [rv_core_pkg::xlen-1:0] reset_pc    = rv_core_pkg::default_reset_pc,
    parameter logic [rv_core_pkg::xlen-1:0] trap_vector = rv_core_pkg::default_trap_vector
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [rv_core_pkg::ilen-1:0]        instruction,    // Word at pc, same cycle
    output logic [rv_core_pkg::xlen-1:0]        pc,
    output rv_core_pkg::bus_req_t               bus,
    input  logic [rv_core_pkg::xlen-1:0]        bus_read_data,
    input  logic                                interrupt_req,
    output logic                                interrupt_ack,
    output logic                                interrupt_pending
);
    import rv_core_pkg::*;

    decoded_t        ir;            // Decode to execute
    wb_t             wb;            // Execute to register file
    logic            flush;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // Instruction register stage
    rv_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .fetch_pc    (pc),
        .flush       (flush),
        .ir          (ir)
    );

    // PC, interrupt and bus control
    rv_execute #(
        .reset_pc    (reset_pc),
        .trap_vector (trap_vector)
    ) u_execute (
        .clk               (clk),
        .reset             (reset),
        .ir                (ir),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .interrupt_req     (interrupt_req),
        .bus_read_data     (bus_read_data),
        .pc                (pc),
        .flush             (flush),
        .rs1_addr          (rs1_addr),
        .rs2_addr          (rs2_addr),
        .bus               (bus),
        .wb                (wb),
        .interrupt_ack     (interrupt_ack),
        .interrupt_pending (interrupt_pending)
    );

    // Register file
    rv_result u_result (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam logic [xlen-1:0] start_pc = default_reset_pc;
    localparam logic [xlen-1:0] trap_pc  = default_trap_vector;

    logic            clk = 1'b0;
    logic            reset = 1'b0;              // Held low from time zero
    logic [ilen-1:0] instruction;
    logic [xlen-1:0] pc;
    bus_req_t        bus;
    logic [xlen-1:0] bus_read_data = '0;
    logic            interrupt_req = 1'b0;
    logic            interrupt_ack;
    logic            interrupt_pending;

    logic [ilen-1:0] prog [0:4095];             // Word index pc[13:2]
    logic [xlen-1:0] data_mem [0:63];           // Dword index addr[8:3]
    logic            read_seen = 1'b0;
    logic [xlen-1:0] read_addr = '0;

    // Reference register file and expected bus traffic
    logic [xlen-1:0] model_x [0:31];
    logic [xlen-1:0] exp_store_addr [0:31];
    logic [xlen-1:0] exp_store_data [0:31];
    logic [xlen-1:0] exp_load_addr [0:7];
    int              n_stores = 0;
    int              n_loads = 0;
    int              prog_len = 0;
    logic [11:0]     place_idx;

    // Progress and one-cycle history, all updated on the rising edge
    int              store_idx = 0;
    int              load_idx = 0;
    int              ack_count = 0;
    logic [xlen-1:0] pc_d1 = '0;
    logic [xlen-1:0] pc_d2 = '0;
    logic [xlen-1:0] return_pc = '0;            // Address fetched just before the trap
    logic            reset_d1 = 1'b0;
    logic            read_d1 = 1'b0;
    logic            write_d1 = 1'b0;
    logic            ack_d1 = 1'b0;
    logic            pending_d1 = 1'b0;
    logic            req_d1 = 1'b0;

    integer          seed = 32'hae2843f9;
    logic [31:0]     rnd;
    int              cycles = 0;
    int              cycle_limit = 1000;        // Replaced once the program is known
    int              irq_cycle = 0;

    rv_core #(
        .reset_pc    (start_pc),
        .trap_vector (trap_pc)
    ) dut (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .pc                (pc),
        .bus               (bus),
        .bus_read_data     (bus_read_data),
        .interrupt_req     (interrupt_req),
        .interrupt_ack     (interrupt_ack),
        .interrupt_pending (interrupt_pending)
    );

    always #2 clk = ~clk;                       // 4 ns period

    assign instruction = prog[pc[13:2]];        // Fetch is combinational

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [xlen-1:0] sign_extend12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    task automatic place_word(input logic [ilen-1:0] word);
        prog[place_idx] = word;
        place_idx = place_idx + 12'd1;
        prog_len++;
    endtask

    task automatic write_model(input logic [4:0] rd, input logic [xlen-1:0] value);
        if (rd != 5'd0) begin
            model_x[rd] = value;                // x0 stays zero
        end
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        place_word({imm, rd, 7'b0110111});
        write_model(rd, {{32{imm[19]}}, imm, 12'h000});
    endtask

    task automatic add_immediate(input logic [4:0] rd, rs1, input logic [11:0] imm);
        place_word({imm, rs1, 3'b000, rd, 7'b0010011});
        write_model(rd, model_x[rs1] + sign_extend12(imm));
    endtask

    task automatic load_dword(input logic [4:0] rd, rs1, input logic [11:0] imm);
        logic [xlen-1:0] addr;
        addr = model_x[rs1] + sign_extend12(imm);
        place_word({imm, rs1, 3'b011, rd, 7'b0000011});
        exp_load_addr[n_loads[2:0]] = addr;
        n_loads++;
        write_model(rd, data_mem[addr[8:3]]);  // Program never loads a stored word
    endtask

    task automatic store_dword(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        logic [xlen-1:0] addr;
        addr = model_x[rs1] + sign_extend12(imm);
        place_word({imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011});
        exp_store_addr[n_stores[4:0]] = addr;
        exp_store_data[n_stores[4:0]] = model_x[rs2];
        n_stores++;
    endtask

    // Data memory, read data shows up one cycle after the strobe
    always @(negedge clk) begin
        if (read_seen) begin
            bus_read_data = data_mem[read_addr[8:3]];
        end
        read_seen = bus.read;
        read_addr = bus.addr;
        if (bus.write) begin
            data_mem[bus.addr[8:3]] = bus.wdata;
        end
    end

    // Level request, held through the handler until the return clears pending
    always @(negedge clk) begin
        if (ack_count > 0 && !interrupt_pending) begin
            interrupt_req = 1'b0;
        end else if (reset && cycles == irq_cycle) begin
            interrupt_req = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles     <= cycles + 1;
        reset_d1   <= reset;
        pc_d1      <= pc;
        pc_d2      <= pc_d1;
        read_d1    <= bus.read;
        write_d1   <= bus.write;
        ack_d1     <= interrupt_ack;
        pending_d1 <= interrupt_pending;
        req_d1     <= interrupt_req;
        if (interrupt_ack) begin
            return_pc <= pc_d2;                 // ir held this word when the trap was taken
            ack_count <= ack_count + 1;
        end
        if (reset && bus.read) begin
            load_idx <= load_idx + 1;
        end
        if (reset && bus.write) begin
            store_idx <= store_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (cycles >= cycle_limit) begin
            stop_on_error("Timeout, the program did not finish within the cycle limit");
        end
    end

    pc_after_reset: assert property (@(posedge clk) $rose(reset) |-> pc == start_pc)
        else stop_on_error($sformatf("FAIL pc after reset got %h expected %h",
                                     $sampled(pc), start_pc));

    quiet_after_reset: assert property (@(posedge clk) $rose(reset) |->
            !bus.read && !bus.write && !interrupt_ack && !interrupt_pending)
        else stop_on_error($sformatf("FAIL bus.read %h bus.write %h interrupt_ack %h %s %h",
            $sampled(bus.read), $sampled(bus.write), $sampled(interrupt_ack),
            "interrupt_pending", $sampled(interrupt_pending)));

    // Advance by 4 unless stalled by a bus op, trapped or returning
    pc_sequence: assert property (@(posedge clk) disable iff (!reset) reset_d1 |->
            (pc == pc_d1 + 64'd4) ||
            ((read_d1 || write_d1) && pc == pc_d1) ||
            (interrupt_ack && pc == trap_pc) ||
            (pending_d1 && !interrupt_pending && pc == return_pc))
        else stop_on_error($sformatf("FAIL pc got %h after pc %h",
            $sampled(pc), $sampled(pc_d1)));

    read_one_cycle: assert property (@(posedge clk) disable iff (!reset) read_d1 |-> !bus.read)
        else stop_on_error("FAIL bus.read got 1 expected 0 right after a read strobe");

    write_one_cycle: assert property (@(posedge clk) disable iff (!reset)
            write_d1 |-> !bus.write)
        else stop_on_error("FAIL bus.write got 1 expected 0 right after a write strobe");

    load_expected: assert property (@(posedge clk) disable iff (!reset)
            bus.read |-> load_idx < n_loads)
        else stop_on_error("A load was issued that the program does not contain");

    load_address: assert property (@(posedge clk) disable iff (!reset)
            bus.read && load_idx < n_loads |-> bus.addr == exp_load_addr[load_idx[2:0]])
        else stop_on_error($sformatf("FAIL bus.addr on read got %h expected %h",
            $sampled(bus.addr), $sampled(exp_load_addr[load_idx[2:0]])));

    store_expected: assert property (@(posedge clk) disable iff (!reset)
            bus.write |-> store_idx < n_stores)
        else stop_on_error("A store was issued beyond the end of the expected list");

    store_address: assert property (@(posedge clk) disable iff (!reset)
            bus.write && store_idx < n_stores |-> bus.addr == exp_store_addr[store_idx[4:0]])
        else stop_on_error($sformatf("FAIL bus.addr on write got %h expected %h",
            $sampled(bus.addr), $sampled(exp_store_addr[store_idx[4:0]])));

    store_data: assert property (@(posedge clk) disable iff (!reset)
            bus.write && store_idx < n_stores |-> bus.wdata == exp_store_data[store_idx[4:0]])
        else stop_on_error($sformatf("FAIL bus.wdata got %h expected %h",
            $sampled(bus.wdata), $sampled(exp_store_data[store_idx[4:0]])));

    trap_entry: assert property (@(posedge clk) disable iff (!reset)
            interrupt_ack |-> pc == trap_pc && interrupt_pending)
        else stop_on_error($sformatf("FAIL pc at interrupt_ack got %h expected %h, pending %h",
            $sampled(pc), trap_pc, $sampled(interrupt_pending)));

    single_ack: assert property (@(posedge clk) disable iff (!reset)
            interrupt_ack |-> req_d1 && !pending_d1 && !ack_d1)
        else stop_on_error("interrupt_ack pulsed again or without a fresh request");

    pending_from_ack: assert property (@(posedge clk) disable iff (!reset)
            interrupt_pending && !pending_d1 |-> interrupt_ack)
        else stop_on_error("interrupt_pending rose without an acknowledge");

    // Pending falls only together with the jump back to the interrupted word
    pending_clear: assert property (@(posedge clk) disable iff (!reset)
            pending_d1 && !interrupt_pending |-> pc == return_pc)
        else stop_on_error($sformatf("FAIL pc when interrupt_pending fell got %h expected %h",
            $sampled(pc), $sampled(return_pc)));

    initial begin
        // Unused words are no-ops whose immediate is the word index
        for (int i = 0; i < 4096; i++) begin
            prog[i[11:0]] = {i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
        for (int i = 0; i < 64; i++) begin
            data_mem[i[5:0]] = {$random(seed), $random(seed)};
        end
        for (int i = 0; i < 32; i++) begin
            model_x[i[4:0]] = '0;
        end

        place_idx = start_pc[13:2];
        load_upper(5'd1, 20'h12345);
        add_immediate(5'd2, 5'd1, 12'h678);
        load_upper(5'd3, 20'h80000);            // Negative upper immediate
        add_immediate(5'd4, 5'd0, 12'hffb);     // -5
        add_immediate(5'd5, 5'd0, 12'h100);     // Store base
        store_dword(5'd1, 5'd5, 12'h000);
        store_dword(5'd2, 5'd5, 12'h008);
        store_dword(5'd3, 5'd5, 12'h010);
        store_dword(5'd4, 5'd5, 12'hff8);       // Negative S offset
        load_dword(5'd6, 5'd0, 12'h040);
        store_dword(5'd6, 5'd5, 12'h018);       // Right behind its load
        load_dword(5'd7, 5'd5, 12'h048);
        add_immediate(5'd8, 5'd7, 12'h001);
        place_word({12'h040, 5'd0, 3'b010, 5'd7, 7'b0000011});  // LW, must leave x7 alone
        store_dword(5'd8, 5'd5, 12'h020);
        add_immediate(5'd0, 5'd4, 12'h007);     // Dropped, x0
        load_upper(5'd0, 20'hfffff);
        store_dword(5'd0, 5'd5, 12'h028);
        store_dword(5'd7, 5'd5, 12'h030);
        prog[trap_pc[13:2]] = mret_word;        // Handler is a bare return

        cycle_limit = 4 * prog_len + 200;
        rnd = $random(seed);
        irq_cycle = 12 + int'(rnd[5:0]) % prog_len;

        repeat (8) @(negedge clk);
        reset = 1'b1;

        while (store_idx < n_stores || ack_count == 0 || interrupt_pending) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);             // Room for a stray strobe

        if (store_idx == n_stores && load_idx == n_loads && ack_count == 1) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error("Run ended with stores, loads or acknowledges missing");
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
rv_core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_rv_core
FILELIST  := rv_core.f
BUILD     := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
